// ==== logic/mixer_pkg.sv ====
package mixer_pkg;

   // sample and oscillator widths.
   localparam int SAMPLE_W    = 12;  // signed I/Q samples and LO components.
   localparam int PHASE_W     = 16;  // phase accumulator and increment.
   localparam int LO_IDX_W    = 4;   // top phase bits that address the table.
   localparam int LO_DEPTH    = 1 << LO_IDX_W;

   // product and output widths.
   localparam int PROD_W      = 25;  // two 24-bit products summed.
   localparam int ROUND_SHIFT = 10;  // scale back after the multiply.
   localparam int OUT_W       = 15;  // rounded result, never overflows.

   // real LO value for bypass, equal to one after the shift.
   localparam int BYPASS_LO   = 1024;

   // mixer operating mode, sampled with each input sample.
   typedef enum logic [1:0] {
      MIX_UP     = 2'd0,  // multiply by the LO.
      MIX_DOWN   = 2'd1,  // multiply by the conjugate LO.
      MIX_BYPASS = 2'd2   // multiply by the real constant.
   } mix_mode_e;

   // 2047*cos(2*pi*k/16), rounded to nearest.
   localparam logic signed [SAMPLE_W-1:0] LO_COS [0:LO_DEPTH-1] = '{
       2047,
       1891,
       1447,
        783,
          0,
       -783,
      -1447,
      -1891,
      -2047,
      -1891,
      -1447,
       -783,
          0,
        783,
       1447,
       1891
   };

   // 2047*sin(2*pi*k/16), rounded to nearest.
   localparam logic signed [SAMPLE_W-1:0] LO_SIN [0:LO_DEPTH-1] = '{
          0,
        783,
       1447,
       1891,
       2047,
       1891,
       1447,
        783,
          0,
       -783,
      -1447,
      -1891,
      -2047,
      -1891,
      -1447,
       -783
   };

endpackage

// ==== logic/mixer_if.sv ====
`timescale 1ns/1ps

// operand pair stream from the LO generator into the multiplier.
interface cpx_pair_if;

   logic                                    valid;
   logic                                    ready;
   logic signed [mixer_pkg::SAMPLE_W-1:0]   x_i;   // input sample, real part.
   logic signed [mixer_pkg::SAMPLE_W-1:0]   x_q;   // input sample, imaginary part.
   logic signed [mixer_pkg::SAMPLE_W-1:0]   y_i;   // oscillator, real part.
   logic signed [mixer_pkg::SAMPLE_W-1:0]   y_q;   // oscillator, imaginary part.

   // producer side, holds valid and data until ready.
   modport source (
      output valid,
      output x_i,
      output x_q,
      output y_i,
      output y_q,
      input  ready
   );

   // consumer side.
   modport sink (
      input  valid,
      input  x_i,
      input  x_q,
      input  y_i,
      input  y_q,
      output ready
   );

endinterface

// ==== logic/lo_pair_gen.sv ====
`timescale 1ns/1ps

module lo_pair_gen (
   input  logic                                  clk,
   input  logic                                  i_rst_n,
   input  logic                                  i_valid,
   output logic                                  o_ready,
   input  logic signed [mixer_pkg::SAMPLE_W-1:0] i_x_i,
   input  logic signed [mixer_pkg::SAMPLE_W-1:0] i_x_q,
   input  logic [mixer_pkg::PHASE_W-1:0]         i_phase_inc,
   input  mixer_pkg::mix_mode_e                  i_mode,
   cpx_pair_if.source                            o_pair
);

   logic [mixer_pkg::PHASE_W-1:0]         phase;
   logic [mixer_pkg::LO_IDX_W-1:0]        lo_idx;
   logic signed [mixer_pkg::SAMPLE_W-1:0] lo_cos;
   logic signed [mixer_pkg::SAMPLE_W-1:0] lo_sin;
   logic signed [mixer_pkg::SAMPLE_W-1:0] y_i_sel;
   logic signed [mixer_pkg::SAMPLE_W-1:0] y_q_sel;
   logic                                  accept;

   logic                                  pair_valid;
   logic signed [mixer_pkg::SAMPLE_W-1:0] pair_x_i;
   logic signed [mixer_pkg::SAMPLE_W-1:0] pair_x_q;
   logic signed [mixer_pkg::SAMPLE_W-1:0] pair_y_i;
   logic signed [mixer_pkg::SAMPLE_W-1:0] pair_y_q;

   // the top bits of the current phase pick the table entry.
   assign lo_idx = phase[mixer_pkg::PHASE_W-1 -: mixer_pkg::LO_IDX_W];
   assign lo_cos = mixer_pkg::LO_COS[lo_idx];
   assign lo_sin = mixer_pkg::LO_SIN[lo_idx];

   // oscillator operand for the selected mode.
   always_comb begin
      case (i_mode)
         mixer_pkg::MIX_UP: begin
            y_i_sel = lo_cos;
            y_q_sel = lo_sin;
         end
         mixer_pkg::MIX_DOWN: begin
            y_i_sel = lo_cos;
            y_q_sel = -lo_sin;  // conjugate.
         end
         default: begin
            y_i_sel = mixer_pkg::SAMPLE_W'(mixer_pkg::BYPASS_LO);
            y_q_sel = '0;
         end
      endcase
   end

   // single register slot, refilled in the same cycle it drains.
   assign o_ready = !pair_valid || o_pair.ready;
   assign accept  = i_valid && o_ready;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phase      <= '0;
         pair_valid <= 1'b0;
      end else if (accept) begin
         phase      <= phase + i_phase_inc;  // wraps modulo 2^16.
         pair_valid <= 1'b1;
      end else if (o_pair.ready) begin
         pair_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         pair_x_i <= i_x_i;
         pair_x_q <= i_x_q;
         pair_y_i <= y_i_sel;
         pair_y_q <= y_q_sel;
      end
   end

   assign o_pair.valid = pair_valid;
   assign o_pair.x_i   = pair_x_i;
   assign o_pair.x_q   = pair_x_q;
   assign o_pair.y_i   = pair_y_i;
   assign o_pair.y_q   = pair_y_q;

   // a pending pair must not change until the multiplier takes it.
   a_pair_hold: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_pair.valid && !o_pair.ready |=> o_pair.valid &&
         $stable(o_pair.x_i) && $stable(o_pair.x_q) &&
         $stable(o_pair.y_i) && $stable(o_pair.y_q)
   );

endmodule

// ==== logic/cpx_multiply.sv ====
`timescale 1ns/1ps

module cpx_multiply (
   input  logic                               clk,
   input  logic                               i_rst_n,
   cpx_pair_if.sink                           i_pair,
   input  logic                               i_out_ready,
   output logic                               o_out_valid,
   output logic signed [mixer_pkg::OUT_W-1:0] o_out_i,
   output logic signed [mixer_pkg::OUT_W-1:0] o_out_q
);

   // (a + jb)(c + jd) = (ac - bd) + j(ad + bc)

   logic                                      advance;
   logic                                      pair_xfer;
   logic                                      out_xfer;

   // valid bit per register stage.
   logic                                      v1;
   logic                                      v2;
   logic                                      v3;
   logic                                      v4;

   // stage 1 and 2 hold the four cross products.
   logic signed [2*mixer_pkg::SAMPLE_W-1:0]   s1_ii;
   logic signed [2*mixer_pkg::SAMPLE_W-1:0]   s1_qq;
   logic signed [2*mixer_pkg::SAMPLE_W-1:0]   s1_iq;
   logic signed [2*mixer_pkg::SAMPLE_W-1:0]   s1_qi;
   logic signed [2*mixer_pkg::SAMPLE_W-1:0]   s2_ii;
   logic signed [2*mixer_pkg::SAMPLE_W-1:0]   s2_qq;
   logic signed [2*mixer_pkg::SAMPLE_W-1:0]   s2_iq;
   logic signed [2*mixer_pkg::SAMPLE_W-1:0]   s2_qi;

   // stage 3 holds difference and sum at full width.
   logic signed [mixer_pkg::PROD_W-1:0]       s3_i;
   logic signed [mixer_pkg::PROD_W-1:0]       s3_q;

   // rounded sums and stage 4.
   logic signed [mixer_pkg::PROD_W-1:0]       rnd_i;
   logic signed [mixer_pkg::PROD_W-1:0]       rnd_q;
   logic signed [mixer_pkg::OUT_W-1:0]        s4_i;
   logic signed [mixer_pkg::OUT_W-1:0]        s4_q;

   logic [2:0]                                inflight;

   // every stage moves at once, or none does.
   assign advance      = !o_out_valid || i_out_ready;
   assign i_pair.ready = advance;
   assign pair_xfer    = i_pair.valid && advance;
   assign out_xfer     = o_out_valid && i_out_ready;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         v1          <= 1'b0;
         v2          <= 1'b0;
         v3          <= 1'b0;
         v4          <= 1'b0;
         o_out_valid <= 1'b0;
      end else if (advance) begin
         v1          <= i_pair.valid;
         v2          <= v1;
         v3          <= v2;
         v4          <= v3;
         o_out_valid <= v4;
      end
   end

   // half an LSB of the output is added before the arithmetic shift.
   always_comb begin
      rnd_i = (s3_i + (mixer_pkg::PROD_W'(1) << (mixer_pkg::ROUND_SHIFT - 1)))
              >>> mixer_pkg::ROUND_SHIFT;
      rnd_q = (s3_q + (mixer_pkg::PROD_W'(1) << (mixer_pkg::ROUND_SHIFT - 1)))
              >>> mixer_pkg::ROUND_SHIFT;
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         s1_ii   <= i_pair.x_i * i_pair.y_i;
         s1_qq   <= i_pair.x_q * i_pair.y_q;
         s1_iq   <= i_pair.x_i * i_pair.y_q;
         s1_qi   <= i_pair.x_q * i_pair.y_i;
         s2_ii   <= s1_ii;
         s2_qq   <= s1_qq;
         s2_iq   <= s1_iq;
         s2_qi   <= s1_qi;
         s3_i    <= s2_ii - s2_qq;
         s3_q    <= s2_iq + s2_qi;
         s4_i    <= rnd_i[mixer_pkg::OUT_W-1:0];  // upper bits are sign only.
         s4_q    <= rnd_q[mixer_pkg::OUT_W-1:0];
         o_out_i <= s4_i;
         o_out_q <= s4_q;
      end
   end

   // samples accepted but not yet delivered.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         inflight <= '0;
      end else begin
         case ({pair_xfer, out_xfer})
            2'b10:   inflight <= inflight + 3'd1;
            2'b01:   inflight <= inflight - 3'd1;
            default: inflight <= inflight;
         endcase
      end
   end

   // a stalled result stays put until it is taken.
   a_out_hold: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_out_valid && !i_out_ready |=> o_out_valid &&
         $stable(o_out_i) && $stable(o_out_q)
   );

   // the valid bits account for every accepted sample and never exceed five.
   a_inflight: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      (inflight <= 3'd5) &&
         (32'(inflight) == $countones({v1, v2, v3, v4, o_out_valid}))
   );

endmodule

// ==== logic/cpx_mixer_top.sv ====
`timescale 1ns/1ps

module cpx_mixer_top (
   input  logic                                  clk,
   input  logic                                  i_rst_n,

   // input sample stream.
   input  logic                                  i_in_valid,
   output logic                                  o_in_ready,
   input  logic signed [mixer_pkg::SAMPLE_W-1:0] i_in_i,
   input  logic signed [mixer_pkg::SAMPLE_W-1:0] i_in_q,

   // sampled along with each accepted input.
   input  logic [mixer_pkg::PHASE_W-1:0]         i_phase_inc,
   input  mixer_pkg::mix_mode_e                  i_mode,

   // mixed output stream.
   output logic                                  o_out_valid,
   input  logic                                  i_out_ready,
   output logic signed [mixer_pkg::OUT_W-1:0]    o_out_i,
   output logic signed [mixer_pkg::OUT_W-1:0]    o_out_q
);

   // sample plus LO operands between the two stages.
   cpx_pair_if pair_if ();

   // phase accumulator, table lookup and mode select.
   lo_pair_gen u_lo_pair_gen (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_valid     (i_in_valid),
      .o_ready     (o_in_ready),
      .i_x_i       (i_in_i),
      .i_x_q       (i_in_q),
      .i_phase_inc (i_phase_inc),
      .i_mode      (i_mode),
      .o_pair      (pair_if.source)
   );

   // five stage complex multiply with rounding.
   cpx_multiply u_cpx_multiply (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_pair      (pair_if.sink),
      .i_out_ready (i_out_ready),
      .o_out_valid (o_out_valid),
      .o_out_i     (o_out_i),
      .o_out_q     (o_out_q)
   );

endmodule

// ==== tb/mixer_checker.sv ====
`timescale 1ns/1ps

module mixer_checker (
   input  logic                                  clk,
   input  logic                                  i_rst_n,
   input  logic                                  i_in_valid,
   input  logic                                  i_in_ready,
   input  logic signed [mixer_pkg::SAMPLE_W-1:0] i_in_i,
   input  logic signed [mixer_pkg::SAMPLE_W-1:0] i_in_q,
   input  logic [mixer_pkg::PHASE_W-1:0]         i_phase_inc,
   input  mixer_pkg::mix_mode_e                  i_mode,
   input  logic                                  i_out_valid,
   input  logic                                  i_out_ready,
   input  logic signed [mixer_pkg::OUT_W-1:0]    i_out_i,
   input  logic signed [mixer_pkg::OUT_W-1:0]    i_out_q,
   input  logic                                  i_final,
   output int                                    o_value_errs,
   output int                                    o_flow_errs,
   output int                                    o_accepted,
   output int                                    o_pending
);

   logic [mixer_pkg::PHASE_W-1:0] phase;  // own copy of the LO phase.
   int                            exp_i_q [$];
   int                            exp_q_q [$];
   int                            delivered;
   bit                            final_done;

   // add half an output LSB, then drop the fraction bits.
   function automatic int scale_round(input int acc);
      return (acc + (1 << (mixer_pkg::ROUND_SHIFT - 1))) >>> mixer_pkg::ROUND_SHIFT;
   endfunction

   always @(posedge clk) begin
      logic [mixer_pkg::LO_IDX_W-1:0] idx;
      int                             y_i;
      int                             y_q;
      int                             want_i;
      int                             want_q;
      if (!i_rst_n) begin
         phase = '0;
      end else begin
         if (i_out_valid && i_out_ready) begin
            if (exp_i_q.size() == 0) begin
               $display("output %0d arrived with no accepted sample behind it", delivered);
               o_flow_errs++;
            end else begin
               want_i = exp_i_q.pop_front();
               want_q = exp_q_q.pop_front();
               if (i_out_i !== mixer_pkg::OUT_W'(want_i)) begin
                  $display("** Error: o_out_i sample %0d expected 0x%h, got 0x%h",
                     delivered, mixer_pkg::OUT_W'(want_i), i_out_i);
                  o_value_errs++;
               end
               if (i_out_q !== mixer_pkg::OUT_W'(want_q)) begin
                  $display("** Error: o_out_q sample %0d expected 0x%h, got 0x%h",
                     delivered, mixer_pkg::OUT_W'(want_q), i_out_q);
                  o_value_errs++;
               end
            end
            delivered++;
         end else if (i_out_valid !== 1'b0 && o_accepted == 0) begin
            $display("o_out_valid was not low before the first sample was accepted");
            o_flow_errs++;
         end
         if (i_in_valid && i_in_ready) begin
            idx = phase[mixer_pkg::PHASE_W-1 -: mixer_pkg::LO_IDX_W];
            case (i_mode)
               mixer_pkg::MIX_UP: begin
                  y_i = int'(mixer_pkg::LO_COS[idx]);
                  y_q = int'(mixer_pkg::LO_SIN[idx]);
               end
               mixer_pkg::MIX_DOWN: begin
                  y_i = int'(mixer_pkg::LO_COS[idx]);
                  y_q = -int'(mixer_pkg::LO_SIN[idx]);  // conjugate LO.
               end
               default: begin
                  y_i = mixer_pkg::BYPASS_LO;
                  y_q = 0;
               end
            endcase
            exp_i_q.push_back(scale_round(int'(i_in_i) * y_i - int'(i_in_q) * y_q));
            exp_q_q.push_back(scale_round(int'(i_in_i) * y_q + int'(i_in_q) * y_i));
            phase = phase + i_phase_inc;  // wraps at 2^16.
            o_accepted++;
         end
         if (i_final && !final_done) begin
            final_done = 1'b1;
            if (exp_i_q.size() != 0) begin
               $display("%0d accepted samples never came out", exp_i_q.size());
               o_flow_errs += exp_i_q.size();
            end
         end
         o_pending = exp_i_q.size();
      end
   end

endmodule

// ==== tb/tb_cpx_mixer.sv ====
`timescale 1ns/1ps

module tb_cpx_mixer;

   localparam int NUM_ROWS   = 26;
   localparam int WAIT_LIMIT = 200;  // cycles allowed for any one wait.

   logic                                  clk;
   logic                                  i_rst_n;
   logic                                  i_in_valid;
   logic                                  o_in_ready;
   logic signed [mixer_pkg::SAMPLE_W-1:0] i_in_i;
   logic signed [mixer_pkg::SAMPLE_W-1:0] i_in_q;
   logic [mixer_pkg::PHASE_W-1:0]         i_phase_inc;
   mixer_pkg::mix_mode_e                  i_mode;
   logic                                  o_out_valid;
   logic                                  i_out_ready = 1'b1;
   logic signed [mixer_pkg::OUT_W-1:0]    o_out_i;
   logic signed [mixer_pkg::OUT_W-1:0]    o_out_q;

   // stimulus table, one input sample per row.
   logic signed [mixer_pkg::SAMPLE_W-1:0] tab_i     [NUM_ROWS];
   logic signed [mixer_pkg::SAMPLE_W-1:0] tab_q     [NUM_ROWS];
   logic [mixer_pkg::PHASE_W-1:0]         tab_inc   [NUM_ROWS];
   mixer_pkg::mix_mode_e                  tab_mode  [NUM_ROWS];
   logic                                  tab_stall [NUM_ROWS];  // output held after accept.

   logic                                  random_bp;
   logic                                  final_req;
   logic [16:0]                           lfsr = 17'd93931;
   int                                    cycle = 0;
   int                                    stall_end = 0;
   int                                    timeouts;
   int                                    value_errs;
   int                                    flow_errs;
   int                                    accepted;
   int                                    pending;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   cpx_mixer_top i_dut (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_in_valid  (i_in_valid),
      .o_in_ready  (o_in_ready),
      .i_in_i      (i_in_i),
      .i_in_q      (i_in_q),
      .i_phase_inc (i_phase_inc),
      .i_mode      (i_mode),
      .o_out_valid (o_out_valid),
      .i_out_ready (i_out_ready),
      .o_out_i     (o_out_i),
      .o_out_q     (o_out_q)
   );

   mixer_checker u_checker (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_in_valid   (i_in_valid),
      .i_in_ready   (o_in_ready),
      .i_in_i       (i_in_i),
      .i_in_q       (i_in_q),
      .i_phase_inc  (i_phase_inc),
      .i_mode       (i_mode),
      .i_out_valid  (o_out_valid),
      .i_out_ready  (i_out_ready),
      .i_out_i      (o_out_i),
      .i_out_q      (o_out_q),
      .i_final      (final_req),
      .o_value_errs (value_errs),
      .o_flow_errs  (flow_errs),
      .o_accepted   (accepted),
      .o_pending    (pending)
   );

   // fibonacci LFSR, taps 17 and 14.
   function automatic logic [16:0] lfsr_step(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   task automatic set_row(input int r, input int xi, input int xq, input int inc,
                          input mixer_pkg::mix_mode_e m, input bit stall);
      tab_i[r]     = mixer_pkg::SAMPLE_W'(xi);
      tab_q[r]     = mixer_pkg::SAMPLE_W'(xq);
      tab_inc[r]   = mixer_pkg::PHASE_W'(inc);
      tab_mode[r]  = m;
      tab_stall[r] = stall;
   endtask

   task automatic load_table();
      set_row( 0, -2048,  2047,     0, mixer_pkg::MIX_BYPASS, 1'b0);  // full scale.
      set_row( 1,  2047, -2048,     0, mixer_pkg::MIX_BYPASS, 1'b1);
      set_row( 2,  1000,     0,  4096, mixer_pkg::MIX_UP,     1'b0);  // one table step each.
      set_row( 3,   700,  -200,  4096, mixer_pkg::MIX_UP,     1'b0);
      set_row( 4,     0,  1000,  4096, mixer_pkg::MIX_UP,     1'b0);
      set_row( 5, -2048, -2048,  4096, mixer_pkg::MIX_UP,     1'b0);
      set_row( 6,  2047,  2047,  4096, mixer_pkg::MIX_UP,     1'b0);
      set_row( 7,  -700,   300,  4096, mixer_pkg::MIX_UP,     1'b0);
      set_row( 8,   512,  -512,  4096, mixer_pkg::MIX_UP,     1'b1);
      set_row( 9,     1,     1,  4096, mixer_pkg::MIX_UP,     1'b0);
      set_row(10,  1500,  -900,  4096, mixer_pkg::MIX_UP,     1'b0);
      set_row(11, -1234,   567,  4096, mixer_pkg::MIX_UP,     1'b0);
      set_row(12,  2047, -2048,  4096, mixer_pkg::MIX_UP,     1'b0);
      set_row(13,  -300, -1800,  4096, mixer_pkg::MIX_UP,     1'b0);
      set_row(14,   800,   800,  4096, mixer_pkg::MIX_UP,     1'b0);
      set_row(15, -2048,     0,  4096, mixer_pkg::MIX_UP,     1'b0);
      set_row(16,     0, -2048,  4096, mixer_pkg::MIX_UP,     1'b1);
      set_row(17,   333,  1777,  4096, mixer_pkg::MIX_UP,     1'b0);
      set_row(18,  1000,     0, 16384, mixer_pkg::MIX_DOWN,   1'b0);  // same as rows 2, 6, 10, 14.
      set_row(19,  2047,  2047, 16384, mixer_pkg::MIX_DOWN,   1'b0);
      set_row(20,  1500,  -900, 16384, mixer_pkg::MIX_DOWN,   1'b1);
      set_row(21,   800,   800, 16384, mixer_pkg::MIX_DOWN,   1'b0);
      set_row(22, -1500,   950, 32767, mixer_pkg::MIX_UP,     1'b0);  // phase wraps below.
      set_row(23,   640, -1280, 36867, mixer_pkg::MIX_DOWN,   1'b0);
      set_row(24, -2048, -2048, 65535, mixer_pkg::MIX_BYPASS, 1'b1);
      set_row(25,  1999,   -77,  4660, mixer_pkg::MIX_UP,     1'b0);
   endtask

   // present one row and wait for the handshake.
   task automatic send_row(input int r);
      int waited;
      i_in_valid  <= 1'b1;
      i_in_i      <= tab_i[r];
      i_in_q      <= tab_q[r];
      i_phase_inc <= tab_inc[r];
      i_mode      <= tab_mode[r];
      waited = 0;
      @(posedge clk);
      while (!o_in_ready && waited < WAIT_LIMIT) begin
         waited++;
         @(posedge clk);
      end
      if (!o_in_ready) begin
         $display("timeout: row %0d was not accepted within %0d cycles", r, WAIT_LIMIT);
         timeouts++;
      end else if (tab_stall[r]) begin
         stall_end <= cycle + 4;
      end
   endtask

   task automatic drain_outputs();
      int waited;
      waited = 0;
      @(negedge clk);
      while (pending != 0 && waited < WAIT_LIMIT) begin
         waited++;
         @(negedge clk);
      end
      if (pending != 0) begin
         $display("timeout: %0d outputs still missing after %0d cycles", pending, WAIT_LIMIT);
         timeouts++;
      end
   endtask

   // output back-pressure: table stalls plus about one cycle in four at random.
   always @(posedge clk) begin
      logic b0;
      logic b1;
      b0 = 1'b1;
      b1 = 1'b1;
      if (random_bp) begin
         lfsr = lfsr_step(lfsr);
         b0   = lfsr[0];
         lfsr = lfsr_step(lfsr);
         b1   = lfsr[0];
      end
      cycle <= cycle + 1;
      if (cycle < stall_end || !(b0 || b1))
         i_out_ready <= 1'b0;
      else
         i_out_ready <= 1'b1;
   end

   initial begin
      int pass_n;
      int r;
      i_rst_n     = 1'b0;
      i_in_valid  = 1'b0;
      i_in_i      = '0;
      i_in_q      = '0;
      i_phase_inc = '0;
      i_mode      = mixer_pkg::MIX_BYPASS;
      random_bp   = 1'b0;
      final_req   = 1'b0;
      timeouts    = 0;
      load_table();
      repeat (10) @(posedge clk);
      i_rst_n <= 1'b1;
      repeat (5) @(posedge clk);  // idle, output must stay quiet.

      // free output first, then random back-pressure.
      for (pass_n = 0; pass_n < 2; pass_n++) begin
         random_bp <= (pass_n == 1);
         for (r = 0; r < NUM_ROWS && timeouts == 0; r++)
            send_row(r);
      end
      i_in_valid <= 1'b0;
      drain_outputs();
      @(posedge clk);
      final_req <= 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      $display("value errors %0d, flow errors %0d, timeouts %0d, samples accepted %0d",
         value_errs, flow_errs, timeouts, accepted);
      if (value_errs == 0 && flow_errs == 0 && timeouts == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// ==== flist.f ====
logic/mixer_pkg.sv
logic/mixer_if.sv
logic/lo_pair_gen.sv
logic/cpx_multiply.sv
logic/cpx_mixer_top.sv
tb/mixer_checker.sv
tb/tb_cpx_mixer.sv

// ==== Makefile ====
TOOL       := verilator
TOP        := tb_cpx_mixer
FLIST      := flist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
